// File: bench/tb_hmc_post_top.sv
`timescale 1ns/1ns

`include "hmc_defines.svh"

module tb_hmc_post_top;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_ROWS    = 6;
  localparam int TIMEOUT_CYC = 1 << `HMC_TIMEOUT_BIT;
  localparam int ROW_CYCLES  = TIMEOUT_CYC + 64;   // Room for one restart
  localparam int ROW_BUDGET  = ROW_CYCLES + 16;    // Plus reset and pass-through
  localparam int CORRUPT_IDX = 5;                  // POST flit number to damage

  logic           USER_CLK;
  logic           USER_RST;
  logic           qpll_lock2, qpll_lock3;
  logic           open_hmc_done2, open_hmc_done3;
  logic           link_tx_valid2, link_tx_ready2, link_rx_valid2, link_rx_ready2;
  logic           link_tx_valid3, link_tx_ready3, link_rx_valid3, link_rx_ready3;
  hmc_pkg::flit_t link_tx_data2, link_rx_data2, link_tx_data3, link_rx_data3;
  logic           user_tx_valid2, user_tx_ready2, user_rx_valid2, user_rx_ready2;
  logic           user_tx_valid3, user_tx_ready3, user_rx_valid3, user_rx_ready3;
  hmc_pkg::flit_t user_tx_data2, user_rx_data2, user_tx_data3, user_rx_data3;
  logic           soft_reset2, soft_reset3, post_done2, post_done3;
  logic           init_done, post_ok;

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  string    row_name       [NUM_ROWS];
  int       row_corrupt    [NUM_ROWS];  // 0 none, else link number
  bit       row_hold_done  [NUM_ROWS];  // open_hmc_done kept low
  int       row_drop       [NUM_ROWS];  // qpll_lock2 low in this cycle, -1 never
  bit       row_rand_ready [NUM_ROWS];
  bit       row_exp_init   [NUM_ROWS];
  bit       row_exp_ok     [NUM_ROWS];
  bit [1:0] row_exp_srst   [NUM_ROWS];  // {link3, link2} soft reset seen

  // Loopback registers and bench state
  logic           pend_v2, pend_v3;
  hmc_pkg::flit_t pend_d2, pend_d3;
  hmc_pkg::flit_t exp_num2, exp_num3;   // Next POST number per link
  logic           ut_valid, ur_ready, force_ready;
  hmc_pkg::flit_t ut_data2, ut_data3;
  int cur, cyc;
  int init_rise, ok_rise, pd2_rise, pd3_rise, sr2_first, sr3_first;
  int errors, row_errors, tests_passed, tests_failed;

  hmc_post_top u_hmc_post_top (.*);

  initial begin
    USER_CLK = 1'b0;
    forever #(CLK_PERIOD / 2) USER_CLK = ~USER_CLK;
  end

  // Run limit from row count and per-row budget
  initial begin
    #(NUM_ROWS * ROW_BUDGET * CLK_PERIOD + 500);
    $display("Watchdog expired at t=%0t, the tests did not finish in time", $time);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic set_row(input int idx, input string name, input int corrupt, input bit hold,
                         input int drop, input bit rnd, input bit e_init, input bit e_ok,
                         input bit [1:0] e_srst);
    row_name[idx]       = name;
    row_corrupt[idx]    = corrupt;
    row_hold_done[idx]  = hold;
    row_drop[idx]       = drop;
    row_rand_ready[idx] = rnd;
    row_exp_init[idx]   = e_init;
    row_exp_ok[idx]     = e_ok;
    row_exp_srst[idx]   = e_srst;
  endtask

  task automatic report_mismatch(input string sig, input hmc_pkg::flit_t got,
                                 input hmc_pkg::flit_t exp);
    $display("Fail t=%0t %s got=%0h expected=%0h", $time, sig, got, exp);
    errors++;
    row_errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error t=%0t %s", $time, msg);
    errors++;
    row_errors++;
  endtask

  task automatic idle_inputs();
    qpll_lock2 = 1'b1;
    qpll_lock3 = 1'b1;
    open_hmc_done2 = 1'b0;
    open_hmc_done3 = 1'b0;
    link_tx_ready2 = 1'b0;
    link_tx_ready3 = 1'b0;
    link_rx_valid2 = 1'b0;
    link_rx_valid3 = 1'b0;
    link_rx_data2 = '0;
    link_rx_data3 = '0;
    user_tx_valid2 = 1'b0;
    user_tx_valid3 = 1'b0;
    user_tx_data2 = '0;
    user_tx_data3 = '0;
    user_rx_ready2 = 1'b0;               // User side idle until hand-over
    user_rx_ready3 = 1'b0;
  endtask

  // Reset held 4 cycles, released on a falling edge
  task automatic apply_reset();
    @(negedge USER_CLK);
    USER_RST = 1'b1;
    idle_inputs();
    pend_v2 = 1'b0;
    pend_v3 = 1'b0;
    pend_d2 = '0;
    pend_d3 = '0;
    exp_num2 = '0;
    exp_num3 = '0;
    ut_valid = 1'b0;
    ur_ready = 1'b0;
    force_ready = 1'b0;
    init_rise = -1;
    ok_rise = -1;
    pd2_rise = -1;
    pd3_rise = -1;
    sr2_first = -1;
    sr3_first = -1;
    repeat (4) @(negedge USER_CLK);
    USER_RST = 1'b0;
  endtask

  // ----------------------------------------------------------
  // One clock cycle of drive and sample
  // ----------------------------------------------------------
  task automatic run_cycle();
    logic fire2;
    logic fire3;
    @(negedge USER_CLK);
    link_rx_valid2 = pend_v2;            // Loopback register output
    link_rx_data2  = pend_d2;
    link_rx_valid3 = pend_v3;
    link_rx_data3  = pend_d3;
    link_tx_ready2 = (force_ready || !row_rand_ready[cur]) ? 1'b1 : ($urandom % 4 != 0);
    link_tx_ready3 = (force_ready || !row_rand_ready[cur]) ? 1'b1 : ($urandom % 4 != 0);
    open_hmc_done2 = !row_hold_done[cur];
    open_hmc_done3 = !row_hold_done[cur];
    qpll_lock2 = (cyc != row_drop[cur]);
    user_tx_valid2 = ut_valid;
    user_tx_valid3 = ut_valid;
    user_tx_data2  = ut_data2;
    user_tx_data3  = ut_data3;
    user_rx_ready2 = ur_ready;
    user_rx_ready3 = ur_ready;
    #1;
    if (init_done && init_rise < 0) init_rise = cyc;
    if (post_ok && ok_rise < 0) ok_rise = cyc;
    if (post_done2 && pd2_rise < 0) pd2_rise = cyc;
    if (post_done3 && pd3_rise < 0) pd3_rise = cyc;
    if (soft_reset2 && sr2_first < 0) sr2_first = cyc;
    if (soft_reset3 && sr3_first < 0) sr3_first = cyc;
    if (cyc == row_drop[cur]) begin
      if (soft_reset2 !== 1'b1) report_mismatch("soft_reset2", soft_reset2, 1);
      if (soft_reset3 !== 1'b0) report_mismatch("soft_reset3", soft_reset3, 0);
    end
    // Link tx_ready reaches the user side, checker takes every word during POST
    if (user_tx_ready2 !== link_tx_ready2)
      report_mismatch("user_tx_ready2", user_tx_ready2, link_tx_ready2);
    if (user_tx_ready3 !== link_tx_ready3)
      report_mismatch("user_tx_ready3", user_tx_ready3, link_tx_ready3);
    if (!post_done2 && link_rx_ready2 !== 1'b1)
      report_mismatch("link_rx_ready2", link_rx_ready2, 1);
    if (!post_done3 && link_rx_ready3 !== 1'b1)
      report_mismatch("link_rx_ready3", link_rx_ready3, 1);
    // Link2 loopback, flushed with the link restart
    fire2 = link_tx_valid2 & link_tx_ready2;
    if (soft_reset2) begin
      pend_v2 = 1'b0;
      exp_num2 = '0;
    end else begin
      pend_v2 = fire2;
      pend_d2 = link_tx_data2;
      if (fire2 && !post_done2) begin
        if (link_tx_data2 !== exp_num2) report_mismatch("link_tx_data2", link_tx_data2, exp_num2);
        if (row_corrupt[cur] == 2 && exp_num2 == CORRUPT_IDX) pend_d2[0] = ~pend_d2[0];
        exp_num2 = exp_num2 + 1;
      end
    end
    // Link3 loopback
    fire3 = link_tx_valid3 & link_tx_ready3;
    if (soft_reset3) begin
      pend_v3 = 1'b0;
      exp_num3 = '0;
    end else begin
      pend_v3 = fire3;
      pend_d3 = link_tx_data3;
      if (fire3 && !post_done3) begin
        if (link_tx_data3 !== exp_num3) report_mismatch("link_tx_data3", link_tx_data3, exp_num3);
        if (row_corrupt[cur] == 3 && exp_num3 == CORRUPT_IDX) pend_d3[0] = ~pend_d3[0];
        exp_num3 = exp_num3 + 1;
      end
    end
  endtask

  task automatic run_row(input int r);
    cur = r;
    row_errors = 0;
    apply_reset();
    for (int c = 0; c < ROW_CYCLES; c++) begin
      cyc = c;
      run_cycle();
      if (c == 0) begin                  // State straight out of reset
        if (link_tx_valid2 !== 1'b0) report_mismatch("link_tx_valid2", link_tx_valid2, 0);
        if (link_tx_valid3 !== 1'b0) report_mismatch("link_tx_valid3", link_tx_valid3, 0);
        if (post_ok !== 1'b0) report_mismatch("post_ok", post_ok, 0);
        if (init_done !== 1'b0) report_mismatch("init_done", init_done, 0);
        if (post_done2 !== 1'b0) report_mismatch("post_done2", post_done2, 0);
        if (post_done3 !== 1'b0) report_mismatch("post_done3", post_done3, 0);
      end
    end
    if (init_done !== row_exp_init[r]) report_mismatch("init_done", init_done, row_exp_init[r]);
    if (post_ok !== row_exp_ok[r]) report_mismatch("post_ok", post_ok, row_exp_ok[r]);
    if (row_exp_init[r]) begin
      if (row_exp_ok[r] && ok_rise != init_rise) report_problem("post_ok not raised with init_done");
      if (pd2_rise != init_rise + 1) report_problem("link2 not handed to user 1 cycle after init");
      if (pd3_rise != init_rise + 1) report_problem("link3 not handed to user 1 cycle after init");
    end else if (init_rise >= 0) begin
      report_problem("init_done rose although POST could not finish");
    end
    if (!row_exp_ok[r] && ok_rise >= 0) report_problem("post_ok rose despite a bad flit");
    if (row_exp_srst[r][0]) begin
      if (sr2_first < 0 || sr2_first > TIMEOUT_CYC + 2) report_problem("soft_reset2 missing");
    end else if (sr2_first >= 0) begin
      report_problem("soft_reset2 pulsed without cause");
    end
    if (row_exp_srst[r][1]) begin
      if (sr3_first < 0 || sr3_first > TIMEOUT_CYC + 2) report_problem("soft_reset3 missing");
    end else if (sr3_first >= 0) begin
      report_problem("soft_reset3 pulsed without cause");
    end
    // User ports pass-through once POST is over
    if (row_exp_init[r]) begin
      ut_valid = 1'b1;
      ut_data2 = {$urandom, $urandom};
      ut_data3 = {$urandom, $urandom};
      force_ready = 1'b1;
      cyc++;
      run_cycle();
      if (link_tx_valid2 !== 1'b1) report_mismatch("link_tx_valid2", link_tx_valid2, 1);
      if (link_tx_data2 !== ut_data2) report_mismatch("link_tx_data2", link_tx_data2, ut_data2);
      if (link_tx_valid3 !== 1'b1) report_mismatch("link_tx_valid3", link_tx_valid3, 1);
      if (link_tx_data3 !== ut_data3) report_mismatch("link_tx_data3", link_tx_data3, ut_data3);
      if (link_rx_ready2 !== 1'b0) report_mismatch("link_rx_ready2", link_rx_ready2, 0);
      if (link_rx_ready3 !== 1'b0) report_mismatch("link_rx_ready3", link_rx_ready3, 0);
      ut_valid = 1'b0;
      ur_ready = 1'b1;
      cyc++;
      run_cycle();                       // Word back through the loopback
      if (user_rx_valid2 !== 1'b1) report_mismatch("user_rx_valid2", user_rx_valid2, 1);
      if (user_rx_data2 !== ut_data2) report_mismatch("user_rx_data2", user_rx_data2, ut_data2);
      if (user_rx_valid3 !== 1'b1) report_mismatch("user_rx_valid3", user_rx_valid3, 1);
      if (user_rx_data3 !== ut_data3) report_mismatch("user_rx_data3", user_rx_data3, ut_data3);
      if (link_rx_ready2 !== 1'b1) report_mismatch("link_rx_ready2", link_rx_ready2, 1);
      if (link_rx_ready3 !== 1'b1) report_mismatch("link_rx_ready3", link_rx_ready3, 1);
    end
    if (row_errors == 0) begin
      tests_passed++;
      $display("Test %0d %s passed", r, row_name[r]);
    end else begin
      tests_failed++;
      $display("Test %0d %s failed with %0d errors", r, row_name[r], row_errors);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(46));
    USER_RST = 1'b1;
    idle_inputs();
    ut_valid = 1'b0;
    ur_ready = 1'b0;
    ut_data2 = '0;
    ut_data3 = '0;
    force_ready = 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    cur = 0;
    cyc = 0;
    //      idx name               crpt hold drop rnd init ok srst
    set_row(0, "clean_post",        0,   0,  -1,  0,  1,   1, 2'b00);
    set_row(1, "back_pressure",     0,   0,  -1,  1,  1,   1, 2'b00);
    set_row(2, "corrupt_link3",     3,   0,  -1,  0,  1,   0, 2'b00);
    set_row(3, "corrupt_link2_bp",  2,   0,  -1,  1,  1,   0, 2'b00);
    set_row(4, "bringup_timeout",   0,   1,  -1,  0,  0,   0, 2'b11);
    set_row(5, "lock_loss_link2",   0,   0,   5,  0,  1,   1, 2'b01);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             NUM_ROWS, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: include/hmc_defines.svh
`ifndef HMC_DEFINES_SVH
`define HMC_DEFINES_SVH

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------

`define HMC_DWIDTH 64        // One flit of POST data
`define HMC_CNT_W 32         // Flit and error counters

// ----------------------------------------------------------
// POST length and bring-up timeout
// ----------------------------------------------------------

// Flit counter bit that marks POST done, 2**4 = 16 flits per link
`define HMC_POST_DONE_BIT 4

// Timeout counter, restart of both links fires at bit 10
`define HMC_TIMEOUT_W 16
`define HMC_TIMEOUT_BIT 10   // 1024 cycles without link init done

// Bit positions must stay inside their counters
// HMC_POST_DONE_BIT < HMC_CNT_W
// HMC_TIMEOUT_BIT < HMC_TIMEOUT_W

`endif

// File: rtl/hmc_link_post.sv
`timescale 1ns/1ns

module hmc_link_post (
  input  logic              USER_CLK,
  input  logic              USER_RST,
  input  logic              soft_reset,
  input  logic              open_hmc_done,
  input  logic              post_done_all,
  // Link side, towards the controller
  output logic              link_tx_valid,
  input  logic              link_tx_ready,
  output hmc_pkg::flit_t    link_tx_data,
  input  logic              link_rx_valid,
  output logic              link_rx_ready,
  input  hmc_pkg::flit_t    link_rx_data,
  // User side, live once POST is done
  input  logic              user_tx_valid,
  output logic              user_tx_ready,
  input  hmc_pkg::flit_t    user_tx_data,
  output logic              user_rx_valid,
  input  logic              user_rx_ready,
  output hmc_pkg::flit_t    user_rx_data,
  // Status to the supervisor
  output hmc_pkg::cnt_t     flit_cnt,
  output hmc_pkg::cnt_t     err_cnt,
  output logic              post_done
);

  logic           gen_tx_valid;
  hmc_pkg::flit_t gen_tx_data;
  logic           chk_rx_ready;

  // ----------------------------------------------------------
  // POST generator and checker
  // ----------------------------------------------------------
  post_flit_gen u_post_flit_gen (
    .USER_CLK      (USER_CLK),
    .USER_RST      (USER_RST),
    .soft_reset    (soft_reset),
    .open_hmc_done (open_hmc_done),
    .post_done_all (post_done_all),
    .tx_ready      (link_tx_ready),  // Shared with user side
    .tx_valid      (gen_tx_valid),
    .tx_data       (gen_tx_data),
    .post_done     (post_done)
  );

  post_flit_check u_post_flit_check (
    .USER_CLK   (USER_CLK),
    .USER_RST   (USER_RST),
    .soft_reset (soft_reset),
    .rx_valid   (link_rx_valid),
    .rx_data    (link_rx_data),
    .rx_ready   (chk_rx_ready),
    .flit_cnt   (flit_cnt),
    .err_cnt    (err_cnt),
    .err_detect ()                   // Counts carry the result upward
  );

  // ----------------------------------------------------------
  // Source selector
  // ----------------------------------------------------------
  // Transmit valid/data from POST until post_done
  assign link_tx_valid = post_done ? user_tx_valid : gen_tx_valid;
  assign link_tx_data  = post_done ? user_tx_data  : gen_tx_data;
  assign user_tx_ready = link_tx_ready;

  // Receive ready from the checker during POST
  assign link_rx_ready = post_done ? user_rx_ready : chk_rx_ready;

  // User sees no receive traffic before hand-over
  assign user_rx_valid = post_done & link_rx_valid;
  assign user_rx_data  = link_rx_data;

endmodule

// File: rtl/hmc_pkg.sv
`include "hmc_defines.svh"

package hmc_pkg;

  // ----------------------------------------------------------
  // Stream and counter types
  // ----------------------------------------------------------

  // Flit payload on both link streams
  typedef logic [`HMC_DWIDTH-1:0] flit_t;

  // Accepted flit count and mismatch count
  typedef logic [`HMC_CNT_W-1:0] cnt_t;

  // POST generator states
  typedef enum logic [1:0] {
    POST_IDLE = 2'd0,  // Waiting on link init done
    POST_SEND = 2'd1,  // Numbered flits going out
    POST_DONE = 2'd2   // Link handed to user side
  } post_state_e;

endpackage

// File: rtl/hmc_post_top.sv
`timescale 1ns/1ns

module hmc_post_top (
  input  logic              USER_CLK,
  input  logic              USER_RST,
  input  logic              qpll_lock2,
  input  logic              qpll_lock3,
  input  logic              open_hmc_done2,
  input  logic              open_hmc_done3,
  // Link2 controller streams
  output logic              link_tx_valid2,
  input  logic              link_tx_ready2,
  output hmc_pkg::flit_t    link_tx_data2,
  input  logic              link_rx_valid2,
  output logic              link_rx_ready2,
  input  hmc_pkg::flit_t    link_rx_data2,
  // Link2 user streams
  input  logic              user_tx_valid2,
  output logic              user_tx_ready2,
  input  hmc_pkg::flit_t    user_tx_data2,
  output logic              user_rx_valid2,
  input  logic              user_rx_ready2,
  output hmc_pkg::flit_t    user_rx_data2,
  // Link3 controller streams
  output logic              link_tx_valid3,
  input  logic              link_tx_ready3,
  output hmc_pkg::flit_t    link_tx_data3,
  input  logic              link_rx_valid3,
  output logic              link_rx_ready3,
  input  hmc_pkg::flit_t    link_rx_data3,
  // Link3 user streams
  input  logic              user_tx_valid3,
  output logic              user_tx_ready3,
  input  hmc_pkg::flit_t    user_tx_data3,
  output logic              user_rx_valid3,
  input  logic              user_rx_ready3,
  output hmc_pkg::flit_t    user_rx_data3,
  // Status
  output logic              soft_reset2,
  output logic              soft_reset3,
  output logic              post_done2,
  output logic              post_done3,
  output logic              init_done,
  output logic              post_ok
);

  hmc_pkg::cnt_t flit_cnt2;
  hmc_pkg::cnt_t flit_cnt3;
  hmc_pkg::cnt_t err_cnt2;
  hmc_pkg::cnt_t err_cnt3;
  logic          post_done_all;

  assign init_done = post_done_all;  // Both links through POST

  // ----------------------------------------------------------
  // Per-link POST and steering
  // ----------------------------------------------------------
  hmc_link_post u_link2 (
    .USER_CLK (USER_CLK), .USER_RST (USER_RST),
    .soft_reset    (soft_reset2),
    .open_hmc_done (open_hmc_done2),
    .post_done_all (post_done_all),
    .link_tx_valid (link_tx_valid2), .link_tx_ready (link_tx_ready2),
    .link_tx_data  (link_tx_data2),
    .link_rx_valid (link_rx_valid2), .link_rx_ready (link_rx_ready2),
    .link_rx_data  (link_rx_data2),
    .user_tx_valid (user_tx_valid2), .user_tx_ready (user_tx_ready2),
    .user_tx_data  (user_tx_data2),
    .user_rx_valid (user_rx_valid2), .user_rx_ready (user_rx_ready2),
    .user_rx_data  (user_rx_data2),
    .flit_cnt (flit_cnt2), .err_cnt (err_cnt2),
    .post_done (post_done2)
  );

  hmc_link_post u_link3 (
    .USER_CLK (USER_CLK), .USER_RST (USER_RST),
    .soft_reset    (soft_reset3),
    .open_hmc_done (open_hmc_done3),
    .post_done_all (post_done_all),
    .link_tx_valid (link_tx_valid3), .link_tx_ready (link_tx_ready3),
    .link_tx_data  (link_tx_data3),
    .link_rx_valid (link_rx_valid3), .link_rx_ready (link_rx_ready3),
    .link_rx_data  (link_rx_data3),
    .user_tx_valid (user_tx_valid3), .user_tx_ready (user_tx_ready3),
    .user_tx_data  (user_tx_data3),
    .user_rx_valid (user_rx_valid3), .user_rx_ready (user_rx_ready3),
    .user_rx_data  (user_rx_data3),
    .flit_cnt (flit_cnt3), .err_cnt (err_cnt3),
    .post_done (post_done3)
  );

  // ----------------------------------------------------------
  // Supervisor for both links
  // ----------------------------------------------------------
  post_supervisor u_post_supervisor (
    .USER_CLK       (USER_CLK),
    .USER_RST       (USER_RST),
    .qpll_lock2     (qpll_lock2),
    .qpll_lock3     (qpll_lock3),
    .open_hmc_done2 (open_hmc_done2),
    .open_hmc_done3 (open_hmc_done3),
    .flit_cnt2      (flit_cnt2),
    .flit_cnt3      (flit_cnt3),
    .err_cnt2       (err_cnt2),
    .err_cnt3       (err_cnt3),
    .soft_reset2    (soft_reset2),
    .soft_reset3    (soft_reset3),
    .post_done_all  (post_done_all),
    .post_ok        (post_ok)
  );

endmodule

// File: rtl/post_flit_check.sv
`timescale 1ns/1ns

module post_flit_check (
  input  logic              USER_CLK,
  input  logic              USER_RST,
  input  logic              soft_reset,
  input  logic              rx_valid,
  input  hmc_pkg::flit_t    rx_data,
  output logic              rx_ready,
  output hmc_pkg::cnt_t     flit_cnt,    // Accepted words
  output hmc_pkg::cnt_t     err_cnt,     // Words off the expected number
  output logic              err_detect   // Sticky after first mismatch
);

  hmc_pkg::flit_t expected;  // Number of the next flit due
  logic           rx_fire;
  logic           mismatch;

  // POST receive side never stalls the link
  assign rx_ready = 1'b1;

  assign rx_fire  = rx_valid & rx_ready;
  assign mismatch = (rx_data != expected);

  // ----------------------------------------------------------
  // Compare and count
  // ----------------------------------------------------------
  always_ff @(posedge USER_CLK or posedge USER_RST) begin
    if (USER_RST) begin
      expected   <= '0;
      flit_cnt   <= '0;
      err_cnt    <= '0;
      err_detect <= 1'b0;
    end else if (soft_reset) begin
      expected   <= '0;
      flit_cnt   <= '0;
      err_cnt    <= '0;
      err_detect <= 1'b0;
    end else if (rx_fire) begin
      // Expected count moves on every word, good or bad
      expected <= expected + 1'b1;
      flit_cnt <= flit_cnt + 1'b1;
      if (mismatch) begin
        err_cnt    <= err_cnt + 1'b1;
        err_detect <= 1'b1;
      end
    end
  end

  // A corrupted flit costs one error only.
  // The number sequence from the generator carries on regardless,
  // so the flit after it matches again.

endmodule

// File: rtl/post_flit_gen.sv
`timescale 1ns/1ns

module post_flit_gen (
  input  logic              USER_CLK,
  input  logic              USER_RST,
  input  logic              soft_reset,     // Sync clear from supervisor
  input  logic              open_hmc_done,  // Link init done
  input  logic              post_done_all,  // Both links passed POST
  input  logic              tx_ready,
  output logic              tx_valid,
  output hmc_pkg::flit_t    tx_data,
  output logic              post_done
);

  hmc_pkg::post_state_e state;

  // Word accepted by the link this cycle
  logic tx_fire;

  assign tx_fire = tx_valid & tx_ready;

  // ----------------------------------------------------------
  // Generator FSM
  // ----------------------------------------------------------
  // tx_data doubles as the flit number, zero based
  always_ff @(posedge USER_CLK or posedge USER_RST) begin
    if (USER_RST) begin
      state    <= hmc_pkg::POST_IDLE;
      tx_valid <= 1'b0;
      tx_data  <= '0;
    end else if (soft_reset) begin
      state    <= hmc_pkg::POST_IDLE;  // Link restart, POST from scratch
      tx_valid <= 1'b0;
      tx_data  <= '0;
    end else begin
      case (state)
        hmc_pkg::POST_IDLE: begin
          if (post_done_all) begin
            // Restarted after POST already passed
            state <= hmc_pkg::POST_DONE;
          end else if (open_hmc_done) begin
            state    <= hmc_pkg::POST_SEND;
            tx_valid <= 1'b1;          // Flit 0 offered next cycle
            tx_data  <= '0;
          end
        end
        hmc_pkg::POST_SEND: begin
          if (post_done_all) begin
            state    <= hmc_pkg::POST_DONE;
            tx_valid <= 1'b0;
          end else if (tx_fire) begin
            tx_data <= tx_data + 1'b1; // Next number after accept
          end
          // No accept means data and valid hold
        end
        hmc_pkg::POST_DONE: begin
          tx_valid <= 1'b0;            // Stays here until a reset
        end
        default: begin
          state    <= hmc_pkg::POST_IDLE;
          tx_valid <= 1'b0;
        end
      endcase
    end
  end

  // Steers the link over to the user ports
  assign post_done = (state == hmc_pkg::POST_DONE);

endmodule

// File: rtl/post_supervisor.sv
`timescale 1ns/1ns

`include "hmc_defines.svh"

module post_supervisor (
  input  logic              USER_CLK,
  input  logic              USER_RST,
  input  logic              qpll_lock2,
  input  logic              qpll_lock3,
  input  logic              open_hmc_done2,
  input  logic              open_hmc_done3,
  input  hmc_pkg::cnt_t     flit_cnt2,
  input  hmc_pkg::cnt_t     flit_cnt3,
  input  hmc_pkg::cnt_t     err_cnt2,
  input  hmc_pkg::cnt_t     err_cnt3,
  output logic              soft_reset2,
  output logic              soft_reset3,
  output logic              post_done_all,  // Also init_done at the top
  output logic              post_ok
);

  logic                      post_done_raw;
  logic                      post_ok_raw;
  logic [1:0]                done_r;        // Edge detect history
  logic [1:0]                ok_r;
  logic [`HMC_TIMEOUT_W-1:0] timeout_cnt;
  logic                      restart;       // One cycle link restart
  logic                      links_up;

  // ----------------------------------------------------------
  // POST result of both links
  // ----------------------------------------------------------
  assign post_done_raw = flit_cnt2[`HMC_POST_DONE_BIT] & flit_cnt3[`HMC_POST_DONE_BIT];
  assign post_ok_raw   = post_done_raw & (err_cnt2 == '0) & (err_cnt3 == '0);

  assign links_up = open_hmc_done2 & open_hmc_done3;

  always_ff @(posedge USER_CLK or posedge USER_RST) begin
    if (USER_RST) begin
      done_r        <= 2'b00;
      ok_r          <= 2'b00;
      post_done_all <= 1'b0;
      post_ok       <= 1'b0;
    end else begin
      done_r <= {done_r[0], post_done_raw};
      ok_r   <= {ok_r[0], post_ok_raw};
      if (done_r == 2'b01) begin
        post_done_all <= 1'b1;     // Latched on rising edge only
      end
      if (ok_r == 2'b01) begin
        post_ok <= 1'b1;           // Held until USER_RST
      end
    end
  end

  // ----------------------------------------------------------
  // Bring-up timeout
  // ----------------------------------------------------------
  always_ff @(posedge USER_CLK or posedge USER_RST) begin
    if (USER_RST) begin
      timeout_cnt <= '0;
      restart     <= 1'b0;
    end else begin
      restart <= timeout_cnt[`HMC_TIMEOUT_BIT];
      if (links_up || timeout_cnt[`HMC_TIMEOUT_BIT]) begin
        timeout_cnt <= '0;         // Both links up, or restart fired
      end else begin
        timeout_cnt <= timeout_cnt + 1'b1;
      end
    end
  end

  // Lock loss acts in the same cycle
  assign soft_reset2 = ~qpll_lock2 | restart;
  assign soft_reset3 = ~qpll_lock3 | restart;

endmodule

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module tb_hmc_post_top -o sim_hmc_post \
  && ./obj_dir/sim_hmc_post > sim.log \
  ; cat sim.log \
  && grep -q "^PASS: all tests$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verilog.f
+incdir+include
rtl/hmc_pkg.sv
rtl/post_flit_gen.sv
rtl/post_flit_check.sv
rtl/hmc_link_post.sv
rtl/post_supervisor.sv
rtl/hmc_post_top.sv
bench/tb_hmc_post_top.sv
